// File: aud_testdata.txt
# Op W: offset wdata | R: offset rdata pslverr | F: left right | E: sram_addr data
# Op J: jitter on(1) or off(0) | H: ready-low cycles. All fields hex
R 4 0 0
R 8 0 0
R c 0 0
F 1111 2222
R 2 0 1
R e 0 1
W 0 3
R 4 5 0
E 00000 a001
E 80000 b001
F a001 b001
E 00001 a002
E 80001 b002
F a002 b002
W 0 c
R 4 a 0
F c0de c0df
W 0 3
E 00002 a003
E 80002 b003
F a003 b003
W 0 30
R 4 0 0
R 8 3 0
R c 3 0
W 0 3
E 00000 d001
E 80000 d002
F d001 d002
J 1
E 00001 d003
E 80001 d004
F d003 d004
E 00002 d005
E 80002 d006
F d005 d006
J 0
R 4 5 0
E 00003 e001
E 80003 e002
H 8c
F e001 e002
F e003 e004
R 4 35 0
W 4 30
R 4 5 0

// File: build.f
aud_cfg_pkg.sv
aud_regs_pkg.sv
aud_i2s_rx.sv
aud_channel_recorder.sv
aud_sram_arbiter.sv
aud_apb_regs.sv
aud_recorder_top.sv
tb_aud_recorder.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the recorder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_aud_recorder -f build.f

out=$(./obj_dir/Vtb_aud_recorder 2>&1 || true)
printf '%s\n' "$out"

# Exit status follows the pass line
printf '%s\n' "$out" | grep -qx '=== PASS ==='

// File: tb_aud_recorder.sv
`default_nettype none

module tb_aud_recorder;

    logic                                i_clk;
    logic                                i_rst_n;
    logic                                i_lrc;
    logic                                i_data;
    logic                                i_psel;
    logic                                i_penable;
    logic                                i_pwrite;
    logic [aud_regs_pkg::APB_AW-1:0]     i_paddr;
    logic [aud_regs_pkg::APB_DW-1:0]     i_pwdata;
    logic [aud_regs_pkg::APB_DW-1:0]     o_prdata;
    logic                                o_pready;
    logic                                o_pslverr;
    logic                                i_sram_ready;
    logic                                o_sram_we;
    logic [aud_cfg_pkg::ADDR_W-1:0]      o_sram_addr;
    logic [aud_cfg_pkg::SAMPLE_W-1:0]    o_sram_data;

    logic [aud_cfg_pkg::ADDR_W-1:0]      exp_addr[$];
    logic [aud_cfg_pkg::SAMPLE_W-1:0]    exp_data[$];
    int                                  cycle;
    int                                  limit;
    int                                  hold_until;   // Ready forced low before this cycle
    logic                                jitter_on;
    int                                  seed;

    aud_recorder_top dut0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_lrc        (i_lrc),
        .i_data       (i_data),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .i_sram_ready (i_sram_ready),
        .o_sram_we    (o_sram_we),
        .o_sram_addr  (o_sram_addr),
        .o_sram_data  (o_sram_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at first error");
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_sram(input logic [aud_cfg_pkg::ADDR_W-1:0] got_addr,
                              input logic [aud_cfg_pkg::SAMPLE_W-1:0] got_data,
                              input logic [aud_cfg_pkg::ADDR_W-1:0] want_addr,
                              input logic [aud_cfg_pkg::SAMPLE_W-1:0] want_data);
        if (got_addr !== want_addr) begin
            fail_run($sformatf("Mismatch at time %0t: o_sram_addr got %h expected %h",
                               $time, got_addr, want_addr));
        end else if (got_data !== want_data) begin
            fail_run($sformatf("Mismatch at time %0t: o_sram_data got %h expected %h",
                               $time, got_data, want_data));
        end
    endtask

    task automatic check_apb(input logic [aud_regs_pkg::APB_DW-1:0] got_data,
                             input logic got_err,
                             input logic [aud_regs_pkg::APB_DW-1:0] want_data,
                             input logic want_err);
        if (got_data !== want_data) begin
            fail_run($sformatf("Mismatch at time %0t: o_prdata got %h expected %h",
                               $time, got_data, want_data));
        end else if (got_err !== want_err) begin
            fail_run($sformatf("Mismatch at time %0t: o_pslverr got %b expected %b",
                               $time, got_err, want_err));
        end
    endtask

    // Zero wait states, so ready is high in every access phase
    task automatic check_ready(input logic got_ready);
        if (got_ready !== 1'b1) begin
            fail_run($sformatf("Mismatch at time %0t: o_pready got %b expected %b",
                               $time, got_ready, 1'b1));
        end
    endtask

    ////////////////////
    // Bus and codec drivers
    ////////////////////
    task automatic apb_write(input logic [aud_regs_pkg::APB_AW-1:0] addr,
                             input logic [aud_regs_pkg::APB_DW-1:0] wdata);
        logic got_ready;
        @(posedge i_clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b1;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge i_clk);
        i_penable <= 1'b1;
        @(negedge i_clk);                            // Mid access phase
        got_ready = o_pready;
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        check_ready(got_ready);
    endtask

    task automatic apb_read(input logic [aud_regs_pkg::APB_AW-1:0] addr,
                            input logic [aud_regs_pkg::APB_DW-1:0] want_data,
                            input logic want_err);
        logic [aud_regs_pkg::APB_DW-1:0] got_data;
        logic                            got_err;
        logic                            got_ready;
        @(posedge i_clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        i_paddr   <= addr;
        @(posedge i_clk);
        i_penable <= 1'b1;
        @(negedge i_clk);                            // Mid access phase
        got_data  = o_prdata;
        got_err   = o_pslverr;
        got_ready = o_pready;
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        check_ready(got_ready);
        check_apb(got_data, got_err, want_data, want_err);
    endtask

    // Slot index 0 carries the LRC change and index 1 the delay bit
    task automatic drive_frame(input logic [aud_cfg_pkg::SAMPLE_W-1:0] left,
                               input logic [aud_cfg_pkg::SAMPLE_W-1:0] right);
        logic [aud_cfg_pkg::SAMPLE_W-1:0] smp;
        for (int ch = 0; ch < aud_cfg_pkg::NUM_CH; ch++) begin
            smp = (ch == 0) ? left : right;
            for (int j = 0; j < aud_cfg_pkg::SLOT_CYCLES; j++) begin
                @(posedge i_clk);
                i_lrc <= (ch != 0);
                if (j >= 2 && j <= aud_cfg_pkg::SAMPLE_W + 1) begin
                    i_data <= smp[aud_cfg_pkg::SAMPLE_W + 1 - j];   // MSB first
                end else begin
                    i_data <= 1'b0;
                end
            end
        end
    endtask

    // SRAM ready with a fixed hold or random stalls
    initial begin
        i_sram_ready <= 1'b1;
        forever begin
            @(posedge i_clk);
            if (cycle < hold_until) begin
                i_sram_ready <= 1'b0;
            end else if (jitter_on) begin
                i_sram_ready <= (($random(seed) & 3) != 0);   // Low one time in four
            end else begin
                i_sram_ready <= 1'b1;
            end
        end
    end

    initial begin
        cycle <= 0;
        forever begin
            @(posedge i_clk);
            cycle <= cycle + 1;
            if (limit != 0 && cycle > limit) begin
                fail_run($sformatf("Timeout: run did not finish within %0d cycles", limit));
            end
        end
    end

    // SRAM write monitor
    always @(negedge i_clk) begin
        if (i_rst_n && o_sram_we) begin
            if (exp_addr.size() == 0) begin
                fail_run($sformatf("Unexpected SRAM write at time %0t to address %h",
                                   $time, o_sram_addr));
            end else begin
                check_sram(o_sram_addr, o_sram_data, exp_addr.pop_front(),
                           exp_data.pop_front());
            end
        end
    end

    ////////////////////
    // Record player
    ////////////////////
    initial begin
        int          fd;
        int          code;
        string       line;
        string       body;
        string       recs[$];
        logic [7:0]  op;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        i_rst_n    <= 1'b0;
        i_lrc      <= 1'b1;                          // Idle on right so left slot shows an edge
        i_data     <= 1'b0;
        i_psel     <= 1'b0;
        i_penable  <= 1'b0;
        i_pwrite   <= 1'b0;
        i_paddr    <= '0;
        i_pwdata   <= '0;
        hold_until <= 0;
        jitter_on  <= 1'b0;
        seed       = 32'hbcb25795;
        limit      = 0;
        fd = $fopen("aud_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open aud_testdata.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin
                recs.push_back(line);
            end
        end
        $fclose(fd);
        limit = recs.size() * 4 * aud_cfg_pkg::SLOT_CYCLES + 200;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;

        foreach (recs[i]) begin
            op   = recs[i].getc(0);
            body = recs[i].substr(1, recs[i].len() - 1);
            a0   = '0;
            a1   = '0;
            a2   = '0;
            code = $sscanf(body, "%h %h %h", a0, a1, a2);
            case (op)
                "W": apb_write(a0[aud_regs_pkg::APB_AW-1:0], a1);
                "R": apb_read(a0[aud_regs_pkg::APB_AW-1:0], a1, a2[0]);
                "F": drive_frame(a0[aud_cfg_pkg::SAMPLE_W-1:0], a1[aud_cfg_pkg::SAMPLE_W-1:0]);
                "E": begin
                    exp_addr.push_back(a0[aud_cfg_pkg::ADDR_W-1:0]);
                    exp_data.push_back(a1[aud_cfg_pkg::SAMPLE_W-1:0]);
                end
                "J": begin
                    @(posedge i_clk);
                    jitter_on <= a0[0];
                end
                "H": begin
                    @(posedge i_clk);
                    hold_until <= cycle + int'(a0);
                end
                default: fail_run($sformatf("Unknown record in test data: %s", recs[i]));
            endcase
        end

        // Let buffered samples drain
        for (int k = 0; k < 300 && exp_addr.size() != 0; k++) begin
            @(posedge i_clk);
        end
        repeat (10) @(posedge i_clk);
        if (exp_addr.size() != 0) begin
            fail_run($sformatf("%0d expected SRAM writes never happened", exp_addr.size()));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: aud_recorder_top.sv
`default_nettype none

module aud_recorder_top (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_lrc,
    input  logic                              i_data,
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  logic [aud_regs_pkg::APB_AW-1:0]   i_paddr,
    input  logic [aud_regs_pkg::APB_DW-1:0]   i_pwdata,
    output logic [aud_regs_pkg::APB_DW-1:0]   o_prdata,
    output logic                              o_pready,
    output logic                              o_pslverr,
    input  logic                              i_sram_ready,
    output logic                              o_sram_we,
    output logic [aud_cfg_pkg::ADDR_W-1:0]    o_sram_addr,
    output logic [aud_cfg_pkg::SAMPLE_W-1:0]  o_sram_data
);

    logic                                                      smp_valid;
    logic [aud_cfg_pkg::SAMPLE_W-1:0]                          smp_data;
    logic [aud_cfg_pkg::CH_W-1:0]                              smp_ch;

    logic [aud_cfg_pkg::NUM_CH-1:0]                            start;
    logic [aud_cfg_pkg::NUM_CH-1:0]                            pause;
    logic [aud_cfg_pkg::NUM_CH-1:0]                            stop;
    logic [aud_cfg_pkg::NUM_CH-1:0]                            clr_ovr;
    logic [aud_cfg_pkg::NUM_CH-1:0]                            grant;

    logic [aud_cfg_pkg::NUM_CH-1:0]                            req;
    logic [aud_cfg_pkg::NUM_CH-1:0][aud_cfg_pkg::ADDR_W-1:0]   addr;
    logic [aud_cfg_pkg::NUM_CH-1:0][aud_cfg_pkg::SAMPLE_W-1:0] data;
    logic [aud_cfg_pkg::NUM_CH-1:0][1:0]                       state;
    logic [aud_cfg_pkg::NUM_CH-1:0]                            ovr;
    logic [aud_cfg_pkg::NUM_CH-1:0][aud_cfg_pkg::REGION_W-1:0] len;

    aud_i2s_rx u_rx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_data      (i_data),
        .o_smp_valid (smp_valid),
        .o_smp_data  (smp_data),
        .o_smp_ch    (smp_ch)
    );

    ////////////////////
    // One recorder per channel
    ////////////////////
    for (genvar c = 0; c < aud_cfg_pkg::NUM_CH; c++) begin : g_rec
        aud_channel_recorder #(
            .CH_INDEX (c)
        ) u_rec (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_smp_valid (smp_valid),
            .i_smp_data  (smp_data),
            .i_smp_ch    (smp_ch),
            .i_start     (start[c]),
            .i_pause     (pause[c]),
            .i_stop      (stop[c]),
            .i_clr_ovr   (clr_ovr[c]),
            .i_grant     (grant[c]),
            .o_req       (req[c]),
            .o_addr      (addr[c]),
            .o_data      (data[c]),
            .o_state     (state[c]),
            .o_ovr       (ovr[c]),
            .o_len       (len[c])
        );
    end

    aud_sram_arbiter u_arb (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (req),
        .i_addr       (addr),
        .i_data       (data),
        .i_sram_ready (i_sram_ready),
        .o_grant      (grant),
        .o_sram_we    (o_sram_we),
        .o_sram_addr  (o_sram_addr),
        .o_sram_data  (o_sram_data)
    );

    aud_apb_regs u_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .i_state   (state),
        .i_ovr     (ovr),
        .i_len     (len),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_start   (start),
        .o_pause   (pause),
        .o_stop    (stop),
        .o_clr_ovr (clr_ovr)
    );

endmodule

`default_nettype wire

// File: aud_apb_regs.sv
`default_nettype none

module aud_apb_regs (
    input  logic                                                      i_clk,
    input  logic                                                      i_rst_n,
    input  logic                                                      i_psel,
    input  logic                                                      i_penable,
    input  logic                                                      i_pwrite,
    input  logic [aud_regs_pkg::APB_AW-1:0]                           i_paddr,
    input  logic [aud_regs_pkg::APB_DW-1:0]                           i_pwdata,
    input  logic [aud_cfg_pkg::NUM_CH-1:0][1:0]                       i_state,
    input  logic [aud_cfg_pkg::NUM_CH-1:0]                            i_ovr,
    input  logic [aud_cfg_pkg::NUM_CH-1:0][aud_cfg_pkg::REGION_W-1:0] i_len,
    output logic [aud_regs_pkg::APB_DW-1:0]                           o_prdata,
    output logic                                                      o_pready,
    output logic                                                      o_pslverr,
    output logic [aud_cfg_pkg::NUM_CH-1:0]                            o_start,
    output logic [aud_cfg_pkg::NUM_CH-1:0]                            o_pause,
    output logic [aud_cfg_pkg::NUM_CH-1:0]                            o_stop,
    output logic [aud_cfg_pkg::NUM_CH-1:0]                            o_clr_ovr
);

    logic access;
    logic hit_ctrl;
    logic hit_status;
    logic hit_len0;
    logic hit_len1;
    logic hit_any;

    assign access     = i_psel && i_penable;
    assign hit_ctrl   = (i_paddr == aud_regs_pkg::REG_CTRL);
    assign hit_status = (i_paddr == aud_regs_pkg::REG_STATUS);
    assign hit_len0   = (i_paddr == aud_regs_pkg::REG_LEN0);
    assign hit_len1   = (i_paddr == aud_regs_pkg::REG_LEN1);
    assign hit_any    = hit_ctrl || hit_status || hit_len0 || hit_len1;

    assign o_pready  = 1'b1;                     // No wait states
    assign o_pslverr = access && !hit_any;

    ////////////////////
    // Read path
    ////////////////////
    always_comb begin
        o_prdata = '0;
        if (hit_status) begin
            for (int c = 0; c < aud_cfg_pkg::NUM_CH; c++) begin
                o_prdata[aud_regs_pkg::ST_STATE_LSB + 2*c +: 2] = i_state[c];
                o_prdata[aud_regs_pkg::ST_OVR_LSB + c]          = i_ovr[c];
            end
        end else if (hit_len0) begin
            o_prdata[aud_cfg_pkg::REGION_W-1:0] = i_len[0];
        end else if (hit_len1) begin
            o_prdata[aud_cfg_pkg::REGION_W-1:0] = i_len[1];
        end
    end

    ////////////////////
    // Command pulses
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_start   <= '0;
            o_pause   <= '0;
            o_stop    <= '0;
            o_clr_ovr <= '0;
        end else begin
            o_start   <= '0;                     // One cycle only
            o_pause   <= '0;
            o_stop    <= '0;
            o_clr_ovr <= '0;
            if (access && i_pwrite && hit_ctrl) begin
                o_start <= i_pwdata[aud_regs_pkg::CMD_START_LSB +: aud_cfg_pkg::NUM_CH];
                o_pause <= i_pwdata[aud_regs_pkg::CMD_PAUSE_LSB +: aud_cfg_pkg::NUM_CH];
                o_stop  <= i_pwdata[aud_regs_pkg::CMD_STOP_LSB +: aud_cfg_pkg::NUM_CH];
            end
            if (access && i_pwrite && hit_status) begin
                o_clr_ovr <= i_pwdata[aud_regs_pkg::ST_OVR_LSB +: aud_cfg_pkg::NUM_CH];
            end
        end
    end

endmodule

`default_nettype wire

// File: aud_sram_arbiter.sv
`default_nettype none

module aud_sram_arbiter (
    input  logic                                                      i_clk,
    input  logic                                                      i_rst_n,
    input  logic [aud_cfg_pkg::NUM_CH-1:0]                            i_req,
    input  logic [aud_cfg_pkg::NUM_CH-1:0][aud_cfg_pkg::ADDR_W-1:0]   i_addr,
    input  logic [aud_cfg_pkg::NUM_CH-1:0][aud_cfg_pkg::SAMPLE_W-1:0] i_data,
    input  logic                                                      i_sram_ready,
    output logic [aud_cfg_pkg::NUM_CH-1:0]                            o_grant,
    output logic                                                      o_sram_we,
    output logic [aud_cfg_pkg::ADDR_W-1:0]                            o_sram_addr,
    output logic [aud_cfg_pkg::SAMPLE_W-1:0]                          o_sram_data
);

    logic [aud_cfg_pkg::CH_W-1:0] last_q;     // Lowest priority next round
    logic [aud_cfg_pkg::CH_W-1:0] win;
    logic                         found;

    // Search starts just after the last winner
    always_comb begin
        int idx;
        o_grant = '0;
        found   = 1'b0;
        win     = last_q;
        for (int k = 1; k <= aud_cfg_pkg::NUM_CH; k++) begin
            idx = (int'(last_q) + k) % aud_cfg_pkg::NUM_CH;
            if (!found && i_sram_ready && i_req[idx]) begin
                o_grant[idx] = 1'b1;
                found        = 1'b1;
                win          = idx[aud_cfg_pkg::CH_W-1:0];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_q    <= '0;
            o_sram_we <= 1'b0;
        end else begin
            o_sram_we <= found;
            if (found) begin
                last_q <= win;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (found) begin
            o_sram_addr <= i_addr[win];
            o_sram_data <= i_data[win];
        end
    end

endmodule

`default_nettype wire

// File: aud_channel_recorder.sv
`default_nettype none

module aud_channel_recorder #(
    parameter int CH_INDEX = 0
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_smp_valid,
    input  logic [aud_cfg_pkg::SAMPLE_W-1:0]  i_smp_data,
    input  logic [aud_cfg_pkg::CH_W-1:0]      i_smp_ch,
    input  logic                              i_start,
    input  logic                              i_pause,
    input  logic                              i_stop,
    input  logic                              i_clr_ovr,
    input  logic                              i_grant,
    output logic                              o_req,
    output logic [aud_cfg_pkg::ADDR_W-1:0]    o_addr,
    output logic [aud_cfg_pkg::SAMPLE_W-1:0]  o_data,
    output logic [1:0]                        o_state,
    output logic                              o_ovr,
    output logic [aud_cfg_pkg::REGION_W-1:0]  o_len
);

    logic [1:0]                       state_q;
    logic [aud_cfg_pkg::REGION_W-1:0] offset_q;
    logic                             full_q;
    logic [aud_cfg_pkg::SAMPLE_W-1:0] buf_q;
    logic                             ovr_q;
    logic                             accept;
    logic                             restart;

    assign accept  = i_smp_valid && (i_smp_ch == CH_INDEX[aud_cfg_pkg::CH_W-1:0])
                     && (state_q == aud_regs_pkg::REC_RUN);
    assign restart = i_start && !i_stop && !i_pause && (state_q == aud_regs_pkg::REC_IDLE);

    assign o_req   = full_q;
    assign o_addr  = {CH_INDEX[aud_cfg_pkg::ADDR_W-aud_cfg_pkg::REGION_W-1:0], offset_q};
    assign o_data  = buf_q;
    assign o_state = state_q;
    assign o_ovr   = ovr_q;
    assign o_len   = offset_q;                   // Words written since start

    ////////////////////
    // Record FSM
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= aud_regs_pkg::REC_IDLE;
        end else if (i_stop) begin
            state_q <= aud_regs_pkg::REC_IDLE;   // Offset kept for LEN
        end else if (i_pause) begin
            if (state_q == aud_regs_pkg::REC_RUN) begin
                state_q <= aud_regs_pkg::REC_PAUSE;
            end
        end else if (i_start) begin
            state_q <= aud_regs_pkg::REC_RUN;    // Resume or fresh start
        end
    end

    ////////////////////
    // Buffer and counters
    ////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            offset_q <= '0;
            full_q   <= 1'b0;
            ovr_q    <= 1'b0;
        end else begin
            if (restart) begin
                offset_q <= '0;
            end else if (i_grant) begin
                offset_q <= offset_q + 1'b1;     // Wraps inside region
            end

            if (accept && full_q && !i_grant) begin
                ovr_q <= 1'b1;                   // Sample lost while buffer full
            end else if (i_clr_ovr) begin
                ovr_q <= 1'b0;
            end

            if (accept && (!full_q || i_grant)) begin
                full_q <= 1'b1;
            end else if (i_grant) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && (!full_q || i_grant)) begin
            buf_q <= i_smp_data;
        end
    end

endmodule

`default_nettype wire

// File: aud_i2s_rx.sv
`default_nettype none

module aud_i2s_rx (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_lrc,
    input  logic                              i_data,
    output logic                              o_smp_valid,
    output logic [aud_cfg_pkg::SAMPLE_W-1:0]  o_smp_data,
    output logic [aud_cfg_pkg::CH_W-1:0]      o_smp_ch
);

    logic                             lrc_q;
    logic                             primed;     // lrc_q holds a real sample
    logic                             lrc_edge;
    logic [4:0]                       bit_cnt;    // 17 means wait for next slot
    logic [aud_cfg_pkg::SAMPLE_W-1:0] shift_q;

    assign lrc_edge   = primed && (i_lrc != lrc_q);
    assign o_smp_data = shift_q;
    assign o_smp_ch   = lrc_q;                    // Channel of the current slot

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrc_q       <= 1'b0;
            primed      <= 1'b0;
            bit_cnt     <= 5'd17;
            o_smp_valid <= 1'b0;
        end else begin
            lrc_q       <= i_lrc;
            primed      <= 1'b1;
            o_smp_valid <= 1'b0;
            if (lrc_edge) begin
                bit_cnt <= 5'd0;                  // Delay bit comes next
            end else if (bit_cnt != 5'd17) begin
                bit_cnt <= bit_cnt + 5'd1;
                if (bit_cnt == 5'd16) begin
                    o_smp_valid <= 1'b1;          // LSB taken this edge
                end
            end
        end
    end

    // Sample bits sit at slot positions 1 to 16
    always_ff @(posedge i_clk) begin
        if (!lrc_edge && bit_cnt >= 5'd1 && bit_cnt <= 5'd16) begin
            shift_q <= {shift_q[aud_cfg_pkg::SAMPLE_W-2:0], i_data};
        end
    end

endmodule

`default_nettype wire

// File: aud_regs_pkg.sv
`default_nettype none

package aud_regs_pkg;

    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    ////////////////////
    // Register offsets
    ////////////////////
    localparam logic [APB_AW-1:0] REG_CTRL   = 4'h0;   // Command pulses, write only
    localparam logic [APB_AW-1:0] REG_STATUS = 4'h4;   // State codes, overrun W1C
    localparam logic [APB_AW-1:0] REG_LEN0   = 4'h8;
    localparam logic [APB_AW-1:0] REG_LEN1   = 4'hc;

    // CTRL fields, one bit per channel
    localparam int CMD_START_LSB = 0;
    localparam int CMD_PAUSE_LSB = 2;
    localparam int CMD_STOP_LSB  = 4;

    // STATUS fields
    localparam int ST_STATE_LSB = 0;   // Two bits per channel
    localparam int ST_OVR_LSB   = 4;

    ////////////////////
    // Recorder states
    ////////////////////
    localparam logic [1:0] REC_IDLE  = 2'd0;
    localparam logic [1:0] REC_RUN   = 2'd1;
    localparam logic [1:0] REC_PAUSE = 2'd2;

endpackage

`default_nettype wire

// File: aud_cfg_pkg.sv
`default_nettype none

package aud_cfg_pkg;

    ////////////////////
    // Data path
    ////////////////////
    localparam int NUM_CH   = 2;
    localparam int CH_W     = $clog2(NUM_CH);   // Channel tag width
    localparam int SAMPLE_W = 16;

    ////////////////////
    // Memory map
    ////////////////////
    localparam int ADDR_W   = 20;               // SRAM word address
    localparam int REGION_W = 19;               // One region per channel

    // Codec bit clocks per half frame
    localparam int SLOT_CYCLES = 32;

endpackage

`default_nettype wire
